// File: dec_pkg.sv
package dec_pkg;

   // ************************************************************
   // widths
   // ************************************************************
   localparam int XLEN          = 32;                    // data word
   localparam int NUM_GPR       = 32;                    // architectural registers, x0 included
   localparam int REG_AW        = $clog2(NUM_GPR);       // register index width
   localparam int NBLOAD_DEPTH  = 4;                     // outstanding non-blocking loads
   localparam int NBLOAD_TAG_W  = $clog2(NBLOAD_DEPTH);  // load tag width

   // ************************************************************
   // pipeline positions, counted in cycles after D
   // ************************************************************
   localparam int STG_X         = 1;                     // execute
   localparam int STG_R         = 2;                     // result / alu writeback
   localparam int WB_DEPTH      = 3;                     // trace stage

   // ************************************************************
   // types
   // ************************************************************
   typedef logic [XLEN-1:0]         xlen_t;        // register data, result, immediate, instr
   typedef logic [XLEN-1:1]         pc_t;          // halfword pc
   typedef logic [REG_AW-1:0]       reg_addr_t;    // gpr index
   typedef logic [NBLOAD_TAG_W-1:0] nbload_tag_t;  // non-blocking load tag

   // major opcodes in the supported subset
   typedef enum logic [6:0] {
      OP     = 7'b0110011,   // reg-reg alu
      OP_IMM = 7'b0010011,   // reg-imm alu
      LUI    = 7'b0110111,   // upper immediate
      LOAD   = 7'b0000011    // loads, all widths
   } opcode_t;

   // instruction field positions
   localparam int RD_LSB        = 7;
   localparam int RS1_LSB       = 15;
   localparam int RS2_LSB       = 20;

endpackage

// File: dec_ib_ctl.sv
`timescale 1ns/1ps

module dec_ib_ctl
   import dec_pkg::*;
(
   input  logic  clk,
   input  logic  rst_n,             // sync, active low

   input  logic  ifu_i0_valid,      // fetch has an instruction
   input  xlen_t ifu_i0_instr,      // fetched word
   input  pc_t   ifu_i0_pc,         // fetched pc

   input  logic  dec_i0_decode_d,   // D instruction leaves this cycle

   output logic  ib_ready,          // buffer can take one this cycle
   output logic  dec_ib0_valid_d,   // buffer holds an instruction
   output xlen_t dec_i0_instr_d,    // instruction at D
   output pc_t   dec_i0_pc_d        // pc at D
);

   logic ib_load;                   // accept from fetch this edge

   // ready when empty or draining this cycle
   assign ib_ready = ~dec_ib0_valid_d | dec_i0_decode_d;
   assign ib_load  = ifu_i0_valid & ib_ready;

   // ************************************************************
   // valid bit
   // ************************************************************
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         dec_ib0_valid_d <= 1'b0;              // empty out of reset
      end else if (ib_load) begin
         dec_ib0_valid_d <= 1'b1;              // refill, also on decode
      end else if (dec_i0_decode_d) begin
         dec_ib0_valid_d <= 1'b0;              // drained, nothing new
      end
   end

   // payload only moves on a load
   always_ff @(posedge clk) begin
      if (ib_load) begin
         dec_i0_instr_d <= ifu_i0_instr;
         dec_i0_pc_d    <= ifu_i0_pc;
      end
   end

endmodule

// File: dec_decode_ctl.sv
`timescale 1ns/1ps

module dec_decode_ctl
   import dec_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,                        // sync, active low

   input  logic        dec_ib0_valid_d,              // buffer valid
   input  xlen_t       dec_i0_instr_d,               // instruction at D
   input  pc_t         dec_i0_pc_d,                  // pc at D

   input  xlen_t       exu_i0_result_r,              // alu result at R

   input  logic        lsu_nonblock_load_valid_m,    // load accepted at X
   input  nbload_tag_t lsu_nonblock_load_tag_m,      // its tag
   input  logic        lsu_nonblock_load_data_valid, // load data back
   input  nbload_tag_t lsu_nonblock_load_data_tag,   // tag of returning data

   output logic        dec_i0_decode_d,              // D instruction moves on
   output reg_addr_t   dec_i0_rs1_d,                 // rs1 index
   output reg_addr_t   dec_i0_rs2_d,                 // rs2 index
   output logic        dec_i0_rs1_en_d,              // rs1 used
   output logic        dec_i0_rs2_en_d,              // rs2 used
   output xlen_t       dec_i0_immed_d,               // immediate
   output logic        dec_i0_alu_decode_d,          // alu op at D
   output logic        dec_i0_lsu_d,                 // load at D
   output logic        dec_i0_illegal_d,             // unknown opcode

   output logic        dec_i0_wen_r,                 // alu write at R
   output reg_addr_t   dec_i0_waddr_r,
   output xlen_t       dec_i0_wdata_r,

   output logic        dec_nonblock_load_wen,        // load data write
   output reg_addr_t   dec_nonblock_load_waddr,

   output logic        trace_valid,                  // one pulse per instr at WB
   output xlen_t       trace_insn,
   output pc_t         trace_pc
);

   opcode_t     opc;                                 // major opcode at D
   logic        is_alu;
   logic        is_lsu;
   logic        is_ill;
   logic        use_rs1;
   logic        use_rs2;
   xlen_t       imm;
   reg_addr_t   rd_d;                                // destination at D
   logic        wr_d;                                // D writes a nonzero rd

   logic        rs1_hit;
   logic        rs2_hit;
   logic        rd_hit;
   logic        interlock;

   // X/R/WB pipe, stage s is s cycles after D
   logic        p_valid [1:WB_DEPTH];
   xlen_t       p_instr [1:WB_DEPTH];
   pc_t         p_pc    [1:WB_DEPTH];
   logic        p_wr    [STG_X:STG_R];               // writes rd
   logic        p_ld    [STG_X:STG_R];               // rd comes from the lsu
   reg_addr_t   p_rd    [STG_X:STG_R];

   // non-blocking load tag table
   logic        ld_pend [NBLOAD_DEPTH];
   reg_addr_t   ld_rd   [NBLOAD_DEPTH];

   // ************************************************************
   // decode
   // ************************************************************
   assign opc          = opcode_t'(dec_i0_instr_d[6:0]);
   assign dec_i0_rs1_d = dec_i0_instr_d[RS1_LSB +: REG_AW];
   assign dec_i0_rs2_d = dec_i0_instr_d[RS2_LSB +: REG_AW];
   assign rd_d         = dec_i0_instr_d[RD_LSB +: REG_AW];

   always_comb begin
      is_alu  = 1'b0;
      is_lsu  = 1'b0;
      is_ill  = 1'b0;
      use_rs1 = 1'b0;
      use_rs2 = 1'b0;
      imm     = '0;
      case (opc)
         OP: begin
            is_alu  = 1'b1;
            use_rs1 = 1'b1;
            use_rs2 = 1'b1;                                    // no immediate
         end
         OP_IMM: begin
            is_alu  = 1'b1;
            use_rs1 = 1'b1;
            imm     = {{20{dec_i0_instr_d[31]}}, dec_i0_instr_d[31:20]}; // I imm
         end
         LUI: begin
            is_alu  = 1'b1;
            imm     = {dec_i0_instr_d[31:12], 12'b0};          // U imm
         end
         LOAD: begin
            is_lsu  = 1'b1;
            use_rs1 = 1'b1;
            imm     = {{20{dec_i0_instr_d[31]}}, dec_i0_instr_d[31:20]}; // offset
         end
         default: is_ill = 1'b1;                              // outside the subset
      endcase
   end

   assign dec_i0_rs1_en_d     = dec_ib0_valid_d & use_rs1;
   assign dec_i0_rs2_en_d     = dec_ib0_valid_d & use_rs2;
   assign dec_i0_alu_decode_d = dec_ib0_valid_d & is_alu;
   assign dec_i0_lsu_d        = dec_ib0_valid_d & is_lsu;
   assign dec_i0_illegal_d    = dec_ib0_valid_d & is_ill;
   assign dec_i0_immed_d      = imm;
   assign wr_d                = ~is_ill & (rd_d != '0);        // x0 and illegal write nothing

   // ************************************************************
   // interlock, no bypass
   // ************************************************************
   always_comb begin
      rs1_hit = 1'b0;
      rs2_hit = 1'b0;
      rd_hit  = 1'b0;
      for (int s = STG_X; s <= STG_R; s++) begin               // in-flight writers
         if (p_wr[s] && (p_rd[s] == dec_i0_rs1_d)) rs1_hit = 1'b1;
         if (p_wr[s] && (p_rd[s] == dec_i0_rs2_d)) rs2_hit = 1'b1;
         if (p_wr[s] && (p_rd[s] == rd_d))         rd_hit  = 1'b1;
      end
      for (int t = 0; t < NBLOAD_DEPTH; t++) begin             // pending load dests
         if (ld_pend[t] && (ld_rd[t] == dec_i0_rs1_d)) rs1_hit = 1'b1;
         if (ld_pend[t] && (ld_rd[t] == dec_i0_rs2_d)) rs2_hit = 1'b1;
         if (ld_pend[t] && (ld_rd[t] == rd_d))         rd_hit  = 1'b1;
      end
   end

   // x0 never blocks
   assign interlock = (use_rs1 & (dec_i0_rs1_d != '0) & rs1_hit) |
                      (use_rs2 & (dec_i0_rs2_d != '0) & rs2_hit) |
                      (wr_d & rd_hit);

   assign dec_i0_decode_d = dec_ib0_valid_d & ~interlock;

   // ************************************************************
   // X / R / WB pipe
   // ************************************************************
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int s = 1; s <= WB_DEPTH; s++) p_valid[s] <= 1'b0;
         for (int s = STG_X; s <= STG_R; s++) begin
            p_wr[s] <= 1'b0;
            p_ld[s] <= 1'b0;
         end
      end else begin
         p_valid[1] <= dec_i0_decode_d;                         // bubble when held
         p_wr[STG_X] <= dec_i0_decode_d & wr_d;
         p_ld[STG_X] <= dec_i0_decode_d & is_lsu;
         for (int s = 2; s <= WB_DEPTH; s++) p_valid[s] <= p_valid[s-1];
         p_wr[STG_R] <= p_wr[STG_X];
         p_ld[STG_R] <= p_ld[STG_X];
      end
   end

   always_ff @(posedge clk) begin
      p_instr[1]  <= dec_i0_instr_d;
      p_pc[1]     <= dec_i0_pc_d;
      p_rd[STG_X] <= rd_d;
      for (int s = 2; s <= WB_DEPTH; s++) begin
         p_instr[s] <= p_instr[s-1];
         p_pc[s]    <= p_pc[s-1];
      end
      p_rd[STG_R] <= p_rd[STG_X];
   end

   // alu / lui writeback at R, loads return on port 1
   assign dec_i0_wen_r   = p_wr[STG_R] & ~p_ld[STG_R];
   assign dec_i0_waddr_r = p_rd[STG_R];
   assign dec_i0_wdata_r = exu_i0_result_r;

   // trace straight off the WB flops
   assign trace_valid = p_valid[WB_DEPTH];
   assign trace_insn  = p_instr[WB_DEPTH];
   assign trace_pc    = p_pc[WB_DEPTH];

   // ************************************************************
   // non-blocking load tag table
   // ************************************************************
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int t = 0; t < NBLOAD_DEPTH; t++) ld_pend[t] <= 1'b0;
      end else begin
         if (lsu_nonblock_load_data_valid) ld_pend[lsu_nonblock_load_data_tag] <= 1'b0;
         if (lsu_nonblock_load_valid_m) ld_pend[lsu_nonblock_load_tag_m] <= 1'b1; // alloc wins
      end
   end

   always_ff @(posedge clk) begin
      if (lsu_nonblock_load_valid_m) ld_rd[lsu_nonblock_load_tag_m] <= p_rd[STG_X]; // load rd at X
   end

   assign dec_nonblock_load_waddr = ld_rd[lsu_nonblock_load_data_tag];
   assign dec_nonblock_load_wen   = lsu_nonblock_load_data_valid &
                                    ld_pend[lsu_nonblock_load_data_tag] &
                                    (dec_nonblock_load_waddr != '0);  // x0 loads dropped

endmodule

// File: dec_gpr_ctl.sv
`timescale 1ns/1ps

module dec_gpr_ctl
   import dec_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,      // sync, active low

   input  reg_addr_t raddr0,     // rs1 read
   input  reg_addr_t raddr1,     // rs2 read

   input  logic      wen0,       // pipeline result
   input  reg_addr_t waddr0,
   input  xlen_t     wd0,

   input  logic      wen1,       // non-blocking load data
   input  reg_addr_t waddr1,
   input  xlen_t     wd1,

   output xlen_t     rd0,
   output xlen_t     rd1
);

   xlen_t gpr [1:NUM_GPR-1];     // x1..x31, x0 has no storage
   logic  we0;
   logic  we1;

   // ************************************************************
   // write ports
   // ************************************************************
   assign we0 = rst_n & wen0 & (waddr0 != '0);   // no writes while in reset
   assign we1 = rst_n & wen1 & (waddr1 != '0);

   always_ff @(posedge clk) begin
      if (we0) begin
         gpr[waddr0] <= wd0;
      end
      if (we1) begin
         gpr[waddr1] <= wd1;                     // load data wins a collision
      end
   end

   // ************************************************************
   // read ports, no write-through
   // ************************************************************
   always_comb begin
      rd0 = '0;                                  // x0 reads zero
      if (raddr0 != '0) begin
         rd0 = gpr[raddr0];
      end
   end

   always_comb begin
      rd1 = '0;
      if (raddr1 != '0) begin
         rd1 = gpr[raddr1];
      end
   end

endmodule

// File: dec.sv
`timescale 1ns/1ps

module dec
   import dec_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,                        // sync, active low

   // fetch
   input  logic        ifu_i0_valid,
   input  xlen_t       ifu_i0_instr,
   input  pc_t         ifu_i0_pc,
   output logic        ib_ready,                     // fetch back-pressure

   // decode
   output logic        dec_i0_decode_d,
   output xlen_t       dec_i0_immed_d,
   output logic        dec_i0_rs1_en_d,
   output logic        dec_i0_rs2_en_d,
   output xlen_t       gpr_i0_rs1_d,                 // rs1 operand
   output xlen_t       gpr_i0_rs2_d,                 // rs2 operand
   output logic        dec_i0_alu_decode_d,
   output logic        dec_i0_lsu_d,
   output logic        dec_i0_illegal_d,

   // execute
   input  xlen_t       exu_i0_result_r,              // alu result at R

   // lsu
   input  logic        lsu_nonblock_load_valid_m,
   input  nbload_tag_t lsu_nonblock_load_tag_m,
   input  logic        lsu_nonblock_load_data_valid,
   input  nbload_tag_t lsu_nonblock_load_data_tag,
   input  xlen_t       lsu_nonblock_load_data,

   // trace at WB
   output logic        trace_valid,
   output xlen_t       trace_insn,
   output pc_t         trace_pc
);

   logic      dec_ib0_valid_d;                       // buffer -> decode
   xlen_t     dec_i0_instr_d;
   pc_t       dec_i0_pc_d;
   reg_addr_t dec_i0_rs1_d;                          // decode -> arf read
   reg_addr_t dec_i0_rs2_d;
   logic      dec_i0_wen_r;                          // decode -> arf port 0
   reg_addr_t dec_i0_waddr_r;
   xlen_t     dec_i0_wdata_r;
   logic      dec_nonblock_load_wen;                 // decode -> arf port 1
   reg_addr_t dec_nonblock_load_waddr;

   dec_ib_ctl instbuff (
      .clk             (clk),
      .rst_n           (rst_n),
      .ifu_i0_valid    (ifu_i0_valid),
      .ifu_i0_instr    (ifu_i0_instr),
      .ifu_i0_pc       (ifu_i0_pc),
      .dec_i0_decode_d (dec_i0_decode_d),
      .ib_ready        (ib_ready),
      .dec_ib0_valid_d (dec_ib0_valid_d),
      .dec_i0_instr_d  (dec_i0_instr_d),
      .dec_i0_pc_d     (dec_i0_pc_d)
   );

   dec_decode_ctl decode (
      .clk                          (clk),
      .rst_n                        (rst_n),
      .dec_ib0_valid_d              (dec_ib0_valid_d),
      .dec_i0_instr_d               (dec_i0_instr_d),
      .dec_i0_pc_d                  (dec_i0_pc_d),
      .exu_i0_result_r              (exu_i0_result_r),
      .lsu_nonblock_load_valid_m    (lsu_nonblock_load_valid_m),
      .lsu_nonblock_load_tag_m      (lsu_nonblock_load_tag_m),
      .lsu_nonblock_load_data_valid (lsu_nonblock_load_data_valid),
      .lsu_nonblock_load_data_tag   (lsu_nonblock_load_data_tag),
      .dec_i0_decode_d              (dec_i0_decode_d),
      .dec_i0_rs1_d                 (dec_i0_rs1_d),
      .dec_i0_rs2_d                 (dec_i0_rs2_d),
      .dec_i0_rs1_en_d              (dec_i0_rs1_en_d),
      .dec_i0_rs2_en_d              (dec_i0_rs2_en_d),
      .dec_i0_immed_d               (dec_i0_immed_d),
      .dec_i0_alu_decode_d          (dec_i0_alu_decode_d),
      .dec_i0_lsu_d                 (dec_i0_lsu_d),
      .dec_i0_illegal_d             (dec_i0_illegal_d),
      .dec_i0_wen_r                 (dec_i0_wen_r),
      .dec_i0_waddr_r               (dec_i0_waddr_r),
      .dec_i0_wdata_r               (dec_i0_wdata_r),
      .dec_nonblock_load_wen        (dec_nonblock_load_wen),
      .dec_nonblock_load_waddr      (dec_nonblock_load_waddr),
      .trace_valid                  (trace_valid),
      .trace_insn                   (trace_insn),
      .trace_pc                     (trace_pc)
   );

   dec_gpr_ctl arf (
      .clk    (clk),
      .rst_n  (rst_n),
      .raddr0 (dec_i0_rs1_d),
      .raddr1 (dec_i0_rs2_d),
      .wen0   (dec_i0_wen_r),                        // alu result at R
      .waddr0 (dec_i0_waddr_r),
      .wd0    (dec_i0_wdata_r),
      .wen1   (dec_nonblock_load_wen),               // returning load
      .waddr1 (dec_nonblock_load_waddr),
      .wd1    (lsu_nonblock_load_data),
      .rd0    (gpr_i0_rs1_d),
      .rd1    (gpr_i0_rs2_d)
   );

endmodule

// File: dec_properties.sv
`timescale 1ns/1ps

module dec_properties
   import dec_pkg::*;
(
   input logic      clk,
   input logic      rst_n,
   input logic      dec_i0_decode_d,
   input logic      dec_ib0_valid_d,          // internal buffer valid
   input logic      trace_valid,
   input logic      dec_nonblock_load_wen,
   input reg_addr_t dec_nonblock_load_waddr,
   input logic      ib_ready
);

   // ************************************************************
   // decode and trace
   // ************************************************************
   decode_needs_buffer: assert property (@(posedge clk) disable iff (!rst_n)
      dec_i0_decode_d |-> dec_ib0_valid_d)
      else $error("decode with an empty instruction buffer");

   trace_follows_decode: assert property (@(posedge clk) disable iff (!rst_n)
      trace_valid == $past(dec_i0_decode_d, WB_DEPTH))
      else $error("trace_valid not aligned to decode plus WB_DEPTH");

   // load data port
   load_write_not_x0: assert property (@(posedge clk) disable iff (!rst_n)
      dec_nonblock_load_wen |-> (dec_nonblock_load_waddr != '0))
      else $error("load data write addressed x0");

   ready_after_reset: assert property (@(posedge clk)
      $rose(rst_n) |-> ib_ready)
      else $error("ib_ready low in the first cycle after reset");

endmodule

bind dec dec_properties props (
   .clk                     (clk),
   .rst_n                   (rst_n),
   .dec_i0_decode_d         (dec_i0_decode_d),
   .dec_ib0_valid_d         (dec_ib0_valid_d),
   .trace_valid             (trace_valid),
   .dec_nonblock_load_wen   (dec_nonblock_load_wen),
   .dec_nonblock_load_waddr (dec_nonblock_load_waddr),
   .ib_ready                (ib_ready)
);

// File: tb_dec.sv
`timescale 1ns/1ps

module tb_dec
   import dec_pkg::*;
();

   localparam int NUM_INIT       = NUM_GPR - 1;             // lui x1..x31 first
   localparam int NUM_RAND       = 400;                     // random stream after that
   localparam int NUM_INSTR      = NUM_INIT + NUM_RAND;
   localparam int TIMEOUT_CYCLES = NUM_INSTR * 40;

   logic        clk = 1'b0;
   logic        rst_n;
   logic        ifu_i0_valid;
   xlen_t       ifu_i0_instr;
   pc_t         ifu_i0_pc;
   logic        ib_ready;
   logic        dec_i0_decode_d;
   xlen_t       dec_i0_immed_d;
   logic        dec_i0_rs1_en_d;
   logic        dec_i0_rs2_en_d;
   xlen_t       gpr_i0_rs1_d;
   xlen_t       gpr_i0_rs2_d;
   logic        dec_i0_alu_decode_d;
   logic        dec_i0_lsu_d;
   logic        dec_i0_illegal_d;
   xlen_t       exu_i0_result_r;
   logic        lsu_nonblock_load_valid_m;
   nbload_tag_t lsu_nonblock_load_tag_m;
   logic        lsu_nonblock_load_data_valid;
   nbload_tag_t lsu_nonblock_load_data_tag;
   xlen_t       lsu_nonblock_load_data;
   logic        trace_valid;
   xlen_t       trace_insn;
   pc_t         trace_pc;

   // ************************************************************
   // reference model state
   // ************************************************************
   xlen_t       regs [NUM_GPR];                             // x0 stays zero
   xlen_t       buf_insn_q [$];                             // accepted but not decoded
   pc_t         buf_pc_q [$];
   xlen_t       exp_insn_q [$];                             // decoded with trace still due
   pc_t         exp_pc_q [$];
   int          exp_due_q [$];
   logic        x_wr, x_alu, r_wr, r_alu;                   // in-flight writers
   reg_addr_t   x_rd, r_rd;
   logic        tag_busy [NBLOAD_DEPTH];                    // handed out to a load
   logic        tag_pend [NBLOAD_DEPTH];                    // pending in the dut
   reg_addr_t   tag_rd [NBLOAD_DEPTH];
   int          tag_due [NBLOAD_DEPTH];                     // cycle data may return
   int          cyc, issued, accepted, trace_count, loads_open;
   pc_t         next_pc;
   logic        done;

   dec uut (
      .clk                          (clk),
      .rst_n                        (rst_n),
      .ifu_i0_valid                 (ifu_i0_valid),
      .ifu_i0_instr                 (ifu_i0_instr),
      .ifu_i0_pc                    (ifu_i0_pc),
      .ib_ready                     (ib_ready),
      .dec_i0_decode_d              (dec_i0_decode_d),
      .dec_i0_immed_d               (dec_i0_immed_d),
      .dec_i0_rs1_en_d              (dec_i0_rs1_en_d),
      .dec_i0_rs2_en_d              (dec_i0_rs2_en_d),
      .gpr_i0_rs1_d                 (gpr_i0_rs1_d),
      .gpr_i0_rs2_d                 (gpr_i0_rs2_d),
      .dec_i0_alu_decode_d          (dec_i0_alu_decode_d),
      .dec_i0_lsu_d                 (dec_i0_lsu_d),
      .dec_i0_illegal_d             (dec_i0_illegal_d),
      .exu_i0_result_r              (exu_i0_result_r),
      .lsu_nonblock_load_valid_m    (lsu_nonblock_load_valid_m),
      .lsu_nonblock_load_tag_m      (lsu_nonblock_load_tag_m),
      .lsu_nonblock_load_data_valid (lsu_nonblock_load_data_valid),
      .lsu_nonblock_load_data_tag   (lsu_nonblock_load_data_tag),
      .lsu_nonblock_load_data       (lsu_nonblock_load_data),
      .trace_valid                  (trace_valid),
      .trace_insn                   (trace_insn),
      .trace_pc                     (trace_pc)
   );

   always #5 clk = ~clk;                                    // 10 ns period

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("** Error: %s = %h, expected %h at cycle %0d", name, got, exp, cyc);
         $display("RESULT: FAIL");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic stop_with_error(input string what);
      $display("Error at cycle %0d: %s", cyc, what);
      $display("RESULT: FAIL");
      $fatal(1, "run stopped");
   endtask

   // expected decode straight from the opcode table
   function automatic void expected_decode(input xlen_t w, output logic use1,
                                           output logic use2, output logic alu,
                                           output logic lsu, output logic ill,
                                           output xlen_t imm);
      use1 = 1'b0;
      use2 = 1'b0;
      alu  = 1'b0;
      lsu  = 1'b0;
      ill  = 1'b0;
      imm  = '0;
      if (w[6:0] == OP) begin
         use1 = 1'b1;
         use2 = 1'b1;
         alu  = 1'b1;
      end else if (w[6:0] == OP_IMM || w[6:0] == LOAD) begin
         use1 = 1'b1;
         alu  = (w[6:0] == OP_IMM);
         lsu  = (w[6:0] == LOAD);
         imm  = 32'($signed(w[31:20]));                     // sign-extended I imm
      end else if (w[6:0] == LUI) begin
         alu  = 1'b1;
         imm  = w & 32'hffff_f000;                          // upper 20 bits over zeros
      end else begin
         ill  = 1'b1;
      end
   endfunction

   function automatic logic in_flight(input reg_addr_t r);
      logic hit;
      hit = (x_wr && x_rd == r) || (r_wr && r_rd == r);
      for (int t = 0; t < NBLOAD_DEPTH; t++) begin
         if (tag_pend[t] && tag_rd[t] == r) hit = 1'b1;     // load not back yet
      end
      return hit;
   endfunction

   // interlock model where x0 never matches
   function automatic logic blocked(input xlen_t w);
      logic  use1, use2, alu, lsu, ill;
      xlen_t imm;
      expected_decode(w, use1, use2, alu, lsu, ill, imm);
      return (use1 && w[19:15] != '0 && in_flight(w[19:15])) ||
             (use2 && w[24:20] != '0 && in_flight(w[24:20])) ||
             (!ill && w[11:7] != '0 && in_flight(w[11:7]));
   endfunction

   function automatic reg_addr_t pick_reg();
      if ($urandom_range(0, 1) == 0) return reg_addr_t'($urandom_range(0, 7)); // more hazards
      return reg_addr_t'($urandom_range(0, 31));
   endfunction

   task automatic make_word(input int idx, output xlen_t w);
      int         kind;
      logic [6:0] opc;
      kind = $urandom_range(0, 99);
      if (idx < NUM_INIT) begin
         w = {20'($urandom), reg_addr_t'(idx + 1), LUI};    // fill x1..x31
      end else if (kind < 30) begin
         w = {1'b0, 1'($urandom), 5'b0, pick_reg(), pick_reg(), 3'($urandom), pick_reg(), OP};
      end else if (kind < 85 && kind >= 60 && loads_open < NBLOAD_DEPTH) begin
         w = {12'($urandom), pick_reg(), 3'($urandom), pick_reg(), LOAD};
         loads_open++;                                      // tag reserved until data
      end else if (kind < 85) begin
         w = {12'($urandom), pick_reg(), 3'($urandom), pick_reg(), OP_IMM};
      end else if (kind < 91) begin
         w = {20'($urandom), pick_reg(), LUI};
      end else begin
         do opc = 7'($urandom);
         while (opc == OP || opc == OP_IMM || opc == LUI || opc == LOAD);
         w = {25'($urandom), opc};                          // illegal encoding
      end
   endtask

   // ************************************************************
   // check, update the model and drive the next cycle at each edge
   // ************************************************************
   task automatic run_cycle();
      logic        dv, exp_dv, use1, use2, alu, lsu, ill, new_wr, new_alu, new_ld, sent;
      xlen_t       w, imm;
      pc_t         pc;
      reg_addr_t   rd;
      int          base;
      nbload_tag_t cand;
      dv     = dec_i0_decode_d;
      exp_dv = (buf_insn_q.size() != 0) && !blocked(buf_insn_q[0]);
      check_value("dec_i0_decode_d", 32'(dv), 32'(exp_dv));
      check_value("ib_ready", 32'(ib_ready), 32'(buf_insn_q.size() == 0 || exp_dv));
      new_wr  = 1'b0;
      new_alu = 1'b0;
      new_ld  = 1'b0;
      rd      = '0;
      if (dv) begin
         w  = buf_insn_q.pop_front();
         pc = buf_pc_q.pop_front();
         expected_decode(w, use1, use2, alu, lsu, ill, imm);
         check_value("dec_i0_rs1_en_d", 32'(dec_i0_rs1_en_d), 32'(use1));
         check_value("dec_i0_rs2_en_d", 32'(dec_i0_rs2_en_d), 32'(use2));
         check_value("dec_i0_alu_decode_d", 32'(dec_i0_alu_decode_d), 32'(alu));
         check_value("dec_i0_lsu_d", 32'(dec_i0_lsu_d), 32'(lsu));
         check_value("dec_i0_illegal_d", 32'(dec_i0_illegal_d), 32'(ill));
         if (!ill && !use2) check_value("dec_i0_immed_d", dec_i0_immed_d, imm);
         if (use1) check_value("gpr_i0_rs1_d", gpr_i0_rs1_d, regs[w[19:15]]);
         if (use2) check_value("gpr_i0_rs2_d", gpr_i0_rs2_d, regs[w[24:20]]);
         rd      = w[11:7];
         new_wr  = !ill && rd != '0;
         new_alu = alu && new_wr;
         new_ld  = lsu;
         exp_insn_q.push_back(w);
         exp_pc_q.push_back(pc);
         exp_due_q.push_back(cyc + WB_DEPTH);
      end
      if (trace_valid) begin
         if (exp_insn_q.size() == 0) stop_with_error("trace report with nothing decoded");
         check_value("trace_valid cycle", cyc, exp_due_q.pop_front());
         check_value("trace_insn", trace_insn, exp_insn_q.pop_front());
         check_value("trace_pc", 32'(trace_pc), 32'(exp_pc_q.pop_front()));
         trace_count++;
      end else if (exp_due_q.size() != 0 && exp_due_q[0] == cyc) begin
         stop_with_error("no trace report for a decoded instruction");
      end
      // state changes at this edge
      if (r_alu) regs[r_rd] = exu_i0_result_r;             // R-stage writeback
      if (lsu_nonblock_load_valid_m) tag_pend[lsu_nonblock_load_tag_m] = 1'b1;
      if (lsu_nonblock_load_data_valid) begin
         if (tag_rd[lsu_nonblock_load_data_tag] != '0)
            regs[tag_rd[lsu_nonblock_load_data_tag]] = lsu_nonblock_load_data; // load wins
         tag_pend[lsu_nonblock_load_data_tag] = 1'b0;
         tag_busy[lsu_nonblock_load_data_tag] = 1'b0;
         loads_open--;
      end
      if (ifu_i0_valid && ib_ready) begin
         buf_insn_q.push_back(ifu_i0_instr);
         buf_pc_q.push_back(ifu_i0_pc);
         accepted++;
      end
      r_wr  = x_wr;
      r_alu = x_alu;
      r_rd  = x_rd;
      x_wr  = new_wr;
      x_alu = new_alu;
      x_rd  = rd;
      // drive the next cycle
      exu_i0_result_r              <= $urandom;
      lsu_nonblock_load_valid_m    <= 1'b0;
      lsu_nonblock_load_data_valid <= 1'b0;
      if (new_ld) begin
         sent = 1'b0;
         base = $urandom_range(0, NBLOAD_DEPTH - 1);         // random free tag
         for (int k = 0; k < NBLOAD_DEPTH; k++) begin
            cand = nbload_tag_t'(base + k);
            if (!sent && !tag_busy[cand]) begin
               sent           = 1'b1;
               tag_busy[cand] = 1'b1;
               tag_rd[cand]   = rd;
               tag_due[cand]  = cyc + 1 + $urandom_range(1, 12);
               lsu_nonblock_load_valid_m <= 1'b1;
               lsu_nonblock_load_tag_m   <= cand;
            end
         end
         if (!sent) stop_with_error("no free load tag for a decoded load");
      end
      sent = 1'b0;
      for (int k = 0; k < NBLOAD_DEPTH; k++) begin
         if (!sent && tag_pend[k] && tag_due[k] <= cyc + 1) begin
            sent = 1'b1;                                    // one return per cycle
            lsu_nonblock_load_data_valid <= 1'b1;
            lsu_nonblock_load_data_tag   <= nbload_tag_t'(k);
            lsu_nonblock_load_data       <= $urandom;
         end
      end
      if (!ifu_i0_valid || ib_ready) begin                  // otherwise hold
         if (issued < NUM_INSTR && $urandom_range(0, 3) != 0) begin
            make_word(issued, w);
            ifu_i0_valid <= 1'b1;
            ifu_i0_instr <= w;
            ifu_i0_pc    <= next_pc;
            next_pc = next_pc + pc_t'(2);
            issued++;
         end else begin
            ifu_i0_valid <= 1'b0;                           // fetch gap
         end
      end
      done = (accepted == NUM_INSTR) && (buf_insn_q.size() == 0) &&
             (exp_insn_q.size() == 0) && (loads_open == 0);
   endtask

   initial begin
      void'($urandom(32'h8538));
      rst_n                        = 1'b0;
      ifu_i0_valid                 = 1'b0;
      ifu_i0_instr                 = '0;
      ifu_i0_pc                    = '0;
      exu_i0_result_r              = '0;
      lsu_nonblock_load_valid_m    = 1'b0;
      lsu_nonblock_load_tag_m      = '0;
      lsu_nonblock_load_data_valid = 1'b0;
      lsu_nonblock_load_data_tag   = '0;
      lsu_nonblock_load_data       = '0;
      for (int i = 0; i < NUM_GPR; i++) regs[i] = '0;
      for (int t = 0; t < NBLOAD_DEPTH; t++) begin
         tag_busy[t] = 1'b0;
         tag_pend[t] = 1'b0;
         tag_rd[t]   = '0;
         tag_due[t]  = 0;
      end
      {x_wr, x_alu, r_wr, r_alu} = '0;
      x_rd        = '0;
      r_rd        = '0;
      cyc         = 0;
      issued      = 0;
      accepted    = 0;
      trace_count = 0;
      loads_open  = 0;
      next_pc     = 31'h0000_0100;
      done        = 1'b0;
      repeat (8) @(posedge clk);
      rst_n <= 1'b1;
      while (!done) begin
         @(posedge clk);
         cyc++;
         run_cycle();
      end
      repeat (WB_DEPTH + 1) begin                           // idle tail catches stray traces
         @(posedge clk);
         cyc++;
         run_cycle();
      end
      check_value("trace report count", trace_count, NUM_INSTR);
      $display("RESULT: PASS");
      $finish;
   end

   // watchdog
   initial begin
      repeat (TIMEOUT_CYCLES) @(posedge clk);
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("RESULT: FAIL");
      $fatal(1, "watchdog expired");
   end

endmodule

// File: list.f
dec_pkg.sv
dec_ib_ctl.sv
dec_decode_ctl.sv
dec_gpr_ctl.sv
dec.sv
dec_properties.sv
tb_dec.sv

// File: Makefile
# Verilator build and run of the dec decode unit testbench

VERILATOR ?= verilator
TOP       ?= tb_dec
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert
PASS_TEXT ?= RESULT: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, check for the pass line"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
